// File: sim.f
uart_pkg.sv
uart_cmd_dispatch.sv
uart_channel.sv
uart_read_collect.sv
uart_bridge_top.sv
tb_clock_gen.sv
tb_uart_device.sv
tb_uart_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART bridge testbench with Verilator, run it and check the log.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  -f sim.f --top-module tb_uart_bridge -o tb_uart_bridge
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_uart_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_uart_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_bridge;

  import uart_pkg::*;

  localparam int BASE_ROWS  = 16;
  localparam int EXTRA_ROWS = 8;
  localparam int NUM_ROWS   = BASE_ROWS + EXTRA_ROWS;
  localparam int ROW_CLKS   = (1 + (22 + GAP_BITS + 3) * CLKS_PER_BIT) * 2;
  localparam int LINE_W     = CHAN_W + 2 + BYTE_W;   // {chan, is_read, inject, byte}.
  localparam int READ_W     = CHAN_W + 1 + BYTE_W;   // {chan, err, data}.

  logic                clk;
  logic                rst_n;
  cmd_t                cmd_in;
  chan_t               cmd_chan;
  logic                cmd_vld;
  logic                cmd_rdy;
  logic [NUM_CHAN-1:0] rx;
  logic [NUM_CHAN-1:0] tx;
  logic                read_vld;
  uart_byte_t          read_data;
  chan_t               read_chan;
  logic                read_err;
  logic [NUM_CHAN-1:0] byte_vld;
  logic [NUM_CHAN-1:0] frame_err;
  logic [NUM_CHAN-1:0] inject_err = '0;
  uart_byte_t          byte_out [NUM_CHAN];

  cmd_t  row_cmd  [NUM_ROWS];
  chan_t row_chan [NUM_ROWS];
  logic  row_wait [NUM_ROWS];   // Wait for completion before the next row.
  logic  row_inj  [NUM_ROWS];

  logic [LINE_W-1:0] line_q [$];
  logic [READ_W-1:0] read_q [$];
  logic [31:0]       lfsr = 32'h21f88586;
  chan_t             last_read_chan;
  int                errors = 0;
  int                checks = 0;

  tb_clock_gen clk_gen (.clk(clk));

  uart_bridge_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_chan  (cmd_chan),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err)
  );

  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_dev
    tb_uart_device dev (
      .clk        (clk),
      .tx         (tx[i]),
      .inject_err (inject_err[i]),
      .rx         (rx[i]),
      .byte_vld   (byte_vld[i]),
      .byte_out   (byte_out[i]),
      .frame_err  (frame_err[i])
    );
  end

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_chan(input string name, input chan_t got, input chan_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic set_row(input int r, input cmd_t c, input chan_t ch, input logic w,
                         input logic inj);
    row_cmd[r]  = c;
    row_chan[r] = ch;
    row_wait[r] = w;
    row_inj[r]  = inj;
  endtask

  task automatic build_table();
    logic [31:0] v;
    chan_t       ch;
    logic        wr;
    logic [6:0]  addr;
    uart_byte_t  data;
    set_row(0,  16'h8155, 2'd0, 1'b1, 1'b0);   // One write per channel.
    set_row(1,  16'h9A3C, 2'd1, 1'b1, 1'b0);
    set_row(2,  16'hC7E1, 2'd2, 1'b1, 1'b0);
    set_row(3,  16'hFF00, 2'd3, 1'b1, 1'b0);
    set_row(4,  16'h1200, 2'd0, 1'b1, 1'b0);   // One read per channel.
    set_row(5,  16'h3400, 2'd1, 1'b1, 1'b0);
    set_row(6,  16'h5600, 2'd2, 1'b1, 1'b1);
    set_row(7,  16'h7F00, 2'd3, 1'b1, 1'b0);
    set_row(8,  16'h2100, 2'd0, 1'b0, 1'b0);   // Back to back on mixed channels.
    set_row(9,  16'hA5A5, 2'd1, 1'b0, 1'b0);
    set_row(10, 16'h0F00, 2'd2, 1'b0, 1'b1);
    set_row(11, 16'h4400, 2'd3, 1'b0, 1'b0);
    set_row(12, 16'h6600, 2'd1, 1'b1, 1'b0);
    set_row(13, 16'h8811, 2'd2, 1'b0, 1'b0);   // Same channel in a row.
    set_row(14, 16'h3300, 2'd2, 1'b0, 1'b0);
    set_row(15, 16'hB122, 2'd2, 1'b1, 1'b0);
    for (int r = BASE_ROWS; r < NUM_ROWS; r++)
    begin
      v = draw_bits(CHAN_W);
      ch = v[CHAN_W-1:0];
      v = draw_bits(1);
      wr = v[0];
      v = draw_bits(7);
      addr = v[6:0];
      v = draw_bits(8);
      data = v[7:0];
      set_row(r, {wr, addr, data}, ch, r == NUM_ROWS - 1, 1'b0);
    end
  endtask

  task automatic push_expected(input int r);
    uart_byte_t hi;
    chan_t      c;
    hi = row_cmd[r][CMD_W-1 -: BYTE_W];
    c  = row_chan[r];
    if (row_cmd[r][CMD_W-1])
    begin
      line_q.push_back({c, 2'b00, hi});
      line_q.push_back({c, 2'b00, row_cmd[r][BYTE_W-1:0]});
    end
    else
    begin
      line_q.push_back({c, 1'b1, row_inj[r], hi});
      read_q.push_back({c, row_inj[r], hi ^ 8'hA5});
    end
  endtask

  // Bytes must arrive in command order per channel.
  task automatic take_line_byte(input chan_t c, input uart_byte_t b, input logic ferr);
    int                idx;
    logic [LINE_W-1:0] e;
    idx = -1;
    for (int i = 0; i < line_q.size(); i++)
    begin
      e = line_q[i];
      if (idx < 0 && e[LINE_W-1 -: CHAN_W] == c)
        idx = i;
    end
    if (idx < 0)
    begin
      $display("Channel %0d sent a byte at %0t that no command asked for", c, $time);
      errors++;
    end
    else
    begin
      e = line_q[idx];
      line_q.delete(idx);
      check_byte($sformatf("tx[%0d] byte", c), b, e[BYTE_W-1:0]);
      check_err($sformatf("tx[%0d] frame_err", c), ferr, 1'b0);
      if (e[BYTE_W+1])
        inject_err[c] <= e[BYTE_W];
    end
  endtask

  task automatic take_read(input chan_t c, input uart_byte_t d, input logic err);
    int                idx;
    logic [READ_W-1:0] e;
    idx = -1;
    for (int i = 0; i < read_q.size(); i++)
    begin
      e = read_q[i];
      if (idx < 0 && e[READ_W-1 -: CHAN_W] == c)
        idx = i;
    end
    last_read_chan = c;
    if (idx < 0)
    begin
      $display("Read result on channel %0d at %0t with no read outstanding", c, $time);
      errors++;
    end
    else
    begin
      e = read_q[idx];
      read_q.delete(idx);
      check_byte("read_data", d, e[BYTE_W-1:0]);
      check_err("read_err", err, e[BYTE_W]);
    end
  endtask

  always @(posedge clk)
  begin
    for (int c = 0; c < NUM_CHAN; c++)
      if (byte_vld[c])
        take_line_byte(chan_t'(c), byte_out[c], frame_err[c]);
  end

  always @(negedge clk)
  begin
    if (read_vld)
      take_read(read_chan, read_data, read_err);
  end

  task automatic send_cmd(input int r);
    int waited;
    waited   = 0;
    cmd_in   = row_cmd[r];
    cmd_chan = row_chan[r];
    cmd_vld  = 1'b1;
    push_expected(r);
    while (!cmd_rdy && waited < ROW_CLKS)
    begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_rdy)
    begin
      $display("Command of row %0d was never accepted", r);
      errors++;
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((line_q.size() != 0 || read_q.size() != 0) && n < 8 * ROW_CLKS)
    begin
      @(negedge clk);
      n++;
    end
    if (line_q.size() != 0 || read_q.size() != 0)
    begin
      $display("Gave up waiting, %0d line bytes and %0d read results missing",
               line_q.size(), read_q.size());
      errors++;
    end
  endtask

  initial
  begin
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_chan = '0;
    cmd_vld  = 1'b0;
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_CHAN; i++)
      check_err($sformatf("tx[%0d]", i), tx[i], 1'b1);
    check_err("cmd_rdy", cmd_rdy, 1'b1);
    check_err("read_vld", read_vld, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      send_cmd(r);
      if (row_wait[r])
      begin
        wait_idle();
        // A lone read owns the last result.
        if ((r == 0 || row_wait[r-1]) && !row_cmd[r][CMD_W-1])
          check_chan("read_chan", last_read_chan, row_chan[r]);
      end
    end
    wait_idle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    repeat (NUM_ROWS * ROW_CLKS) @(posedge clk);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_uart_device.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_device (
  input  logic                 clk,
  input  logic                 tx,
  input  logic                 inject_err,
  output logic                 rx,
  output logic                 byte_vld,
  output uart_pkg::uart_byte_t byte_out,
  output logic                 frame_err
);

  import uart_pkg::*;

  uart_byte_t line_byte;
  logic       par_bit;
  logic       stop_bit;
  logic       low_next;   // Next frame is the low byte of a write.

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Response frame, parity flipped on request.
  task automatic send_frame(input uart_byte_t b, input logic bad_par);
    rx <= 1'b0;
    wait_clks(CLKS_PER_BIT);
    for (int i = 0; i < BYTE_W; i++)
    begin
      rx <= b[i];
      wait_clks(CLKS_PER_BIT);
    end
    rx <= ^b ^ bad_par;
    wait_clks(CLKS_PER_BIT);
    rx <= 1'b1;
    wait_clks(CLKS_PER_BIT / 2);   // Back to listening at mid stop bit.
  endtask

  initial
  begin
    rx        <= 1'b1;
    byte_vld  <= 1'b0;
    byte_out  <= '0;
    frame_err <= 1'b0;
    low_next  = 1'b0;
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        wait_clks(CLKS_PER_BIT / 2);   // Middle of the start bit.
        for (int i = 0; i < BYTE_W; i++)
        begin
          wait_clks(CLKS_PER_BIT);
          line_byte[i] = tx;
        end
        wait_clks(CLKS_PER_BIT);
        par_bit = tx;
        wait_clks(CLKS_PER_BIT);
        stop_bit = tx;
        byte_out  <= line_byte;
        frame_err <= (^line_byte != par_bit) || !stop_bit;
        byte_vld  <= 1'b1;
        @(negedge clk);
        byte_vld  <= 1'b0;
        if (low_next)
          low_next = 1'b0;
        else if (line_byte[BYTE_W-1])
          low_next = 1'b1;     // Write, low byte follows.
        else
        begin
          wait_clks(3 * CLKS_PER_BIT - 1);
          send_frame(line_byte ^ 8'hA5, inject_err);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period.
  end

endmodule

`default_nettype wire

// File: uart_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bridge_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  uart_pkg::cmd_t                cmd_in,
  input  uart_pkg::chan_t               cmd_chan,
  input  logic                          cmd_vld,
  input  logic [uart_pkg::NUM_CHAN-1:0] rx,
  output logic                          cmd_rdy,
  output logic [uart_pkg::NUM_CHAN-1:0] tx,
  output logic                          read_vld,
  output uart_pkg::uart_byte_t          read_data,
  output uart_pkg::chan_t               read_chan,
  output logic                          read_err
);

  import uart_pkg::*;

  cmd_t                          cmd;
  logic       [NUM_CHAN-1:0] start;
  logic       [NUM_CHAN-1:0] idle;
  logic       [NUM_CHAN-1:0] done;
  logic       [NUM_CHAN-1:0] rd_err;
  uart_byte_t [NUM_CHAN-1:0] rd_byte;

  uart_cmd_dispatch u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_chan (cmd_chan),
    .cmd_vld  (cmd_vld),
    .idle     (idle),
    .cmd_rdy  (cmd_rdy),
    .start    (start),
    .cmd      (cmd)
  );

  // One serial engine per channel, all fed the same command word.
  for (genvar i = 0; i < NUM_CHAN; i++)
  begin : g_chan
    uart_channel u_channel (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start[i]),
      .cmd     (cmd),
      .rx      (rx[i]),
      .tx      (tx[i]),
      .idle    (idle[i]),
      .done    (done[i]),
      .rd_byte (rd_byte[i]),
      .rd_err  (rd_err[i])
    );
  end

  uart_read_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .rd_byte   (rd_byte),
    .rd_err    (rd_err),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err)
  );

endmodule

`default_nettype wire

// File: uart_read_collect.sv
`timescale 1ns/100ps
`default_nettype none

module uart_read_collect (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                 [uart_pkg::NUM_CHAN-1:0] done,
  input  uart_pkg::uart_byte_t [uart_pkg::NUM_CHAN-1:0] rd_byte,
  input  logic                 [uart_pkg::NUM_CHAN-1:0] rd_err,
  output logic                                        read_vld,
  output uart_pkg::uart_byte_t                        read_data,
  output uart_pkg::chan_t                             read_chan,
  output logic                                        read_err
);

  import uart_pkg::*;

  logic [NUM_CHAN-1:0] pending;
  logic [NUM_CHAN-1:0] clr;
  uart_byte_t          hold_byte [NUM_CHAN];
  logic                hold_err  [NUM_CHAN];
  chan_t               last;      // Last channel served.
  chan_t               gnt;
  logic                gnt_vld;

  // Search starts one past the last grant.
  always_comb
  begin
    int c;
    gnt_vld = 1'b0;
    gnt     = last;
    for (int k = 1; k <= NUM_CHAN; k++)
    begin
      c = int'(last) + k;
      if (c >= NUM_CHAN)
        c = c - NUM_CHAN;
      if (!gnt_vld && pending[c])
      begin
        gnt_vld = 1'b1;
        gnt     = chan_t'(c);
      end
    end
  end

  assign clr = gnt_vld ? (NUM_CHAN'(1) << gnt) : '0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending  <= '0;
      read_vld <= 1'b0;
      last     <= chan_t'(NUM_CHAN - 1);
    end
    else
    begin
      pending  <= (pending & ~clr) | done;
      read_vld <= gnt_vld;
      if (gnt_vld)
        last <= gnt;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_CHAN; i++)
    begin
      if (done[i])
      begin
        hold_byte[i] <= rd_byte[i];
        hold_err[i]  <= rd_err[i];
      end
    end
    if (gnt_vld)
    begin
      read_data <= hold_byte[gnt];
      read_chan <= gnt;
      read_err  <= hold_err[gnt];
    end
  end

endmodule

`default_nettype wire

// File: uart_channel.sv
`timescale 1ns/100ps
`default_nettype none

module uart_channel (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  uart_pkg::cmd_t       cmd,
  input  logic                 rx,
  output logic                 tx,
  output logic                 idle,
  output logic                 done,
  output uart_pkg::uart_byte_t rd_byte,
  output logic                 rd_err
);

  import uart_pkg::*;

  chan_state_t      state;
  cmd_t             cmd_q;
  uart_byte_t       sh;          // Shared by transmit and receive.
  logic [CNT_W-1:0] bit_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             low_frame;   // Second frame of a write.
  logic             edge_seen;
  logic             rx_par;
  logic             rx_m;
  logic             rx_s;
  logic             rx_d;
  logic             rx_fall;
  logic             tx_par;
  logic             bit_tick;
  logic             mid_tick;
  logic             gap_end;
  logic             last_bit;

  assign idle = (state == IDLE);
  assign done = (state == DONE);

  assign bit_tick = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign mid_tick = (bit_cnt == CNT_W'(MID_CNT));
  assign gap_end  = (bit_cnt == CNT_W'(GAP_CLKS - 1));
  assign last_bit = (bit_idx == IDX_W'(BYTE_W - 1));

  assign tx_par  = ^(low_frame ? cmd_q[BYTE_W-1:0] : cmd_q[CMD_W-1 -: BYTE_W]);  // Even.
  assign rx_fall = rx_d & ~rx_s;

  // Two-flop synchronizer plus one more for the edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_m <= 1'b1;
      rx_s <= 1'b1;
      rx_d <= 1'b1;
    end
    else
    begin
      rx_m <= rx;
      rx_s <= rx_m;
      rx_d <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      tx        <= 1'b1;
      low_frame <= 1'b0;
      edge_seen <= 1'b0;
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        IDLE:
        begin
          bit_cnt <= '0;
          if (start)
          begin
            state     <= TX_START;
            tx        <= 1'b0;
            low_frame <= 1'b0;
          end
        end
        TX_START:
          if (bit_tick)
          begin
            state   <= TX_DATA;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= sh[0];
          end
        TX_DATA:
          if (bit_tick)
          begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (last_bit)
            begin
              state <= TX_PARITY;
              tx    <= tx_par;
            end
            else
            begin
              tx <= sh[1];   // Next bit, sh shifts on this edge.
            end
          end
        TX_PARITY:
          if (bit_tick)
          begin
            state   <= TX_STOP;
            bit_cnt <= '0;
            tx      <= 1'b1;
          end
        TX_STOP:
          if (bit_tick)
          begin
            bit_cnt <= '0;
            if (low_frame)
              state <= IDLE;
            else if (cmd_q[CMD_W-1])
              state <= GAP;
            else
              state <= RX_WAIT;
          end
        GAP:
          if (gap_end)
          begin
            state     <= TX_START;
            bit_cnt   <= '0;
            tx        <= 1'b0;
            low_frame <= 1'b1;
          end
        RX_WAIT:
          if (!edge_seen)
          begin
            bit_cnt   <= '0;
            edge_seen <= rx_fall;
          end
          else if (mid_tick)
          begin
            bit_cnt   <= '0;
            edge_seen <= 1'b0;
            if (!rx_s)
            begin
              state   <= RX_DATA;   // Start bit still low at its middle.
              bit_idx <= '0;
            end
          end
        RX_DATA:
          if (bit_tick)
          begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (last_bit)
              state <= RX_PARITY;
          end
        RX_PARITY:
          if (bit_tick)
          begin
            state   <= RX_STOP;
            bit_cnt <= '0;
          end
        RX_STOP:
          if (bit_tick)
          begin
            state   <= DONE;
            bit_cnt <= '0;
          end
        default:
          state <= IDLE;   // DONE lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
        if (start)
        begin
          cmd_q <= cmd;
          sh    <= cmd[CMD_W-1 -: BYTE_W];
        end
      TX_DATA:
        if (bit_tick)
          sh <= sh >> 1;
      GAP:
        if (gap_end)
          sh <= cmd_q[BYTE_W-1:0];
      RX_DATA:
        if (bit_tick)
          sh <= {rx_s, sh[BYTE_W-1:1]};   // LSB first.
      RX_PARITY:
        if (bit_tick)
          rx_par <= rx_s;
      RX_STOP:
        if (bit_tick)
        begin
          rd_byte <= sh;
          rd_err  <= (^sh ^ rx_par) | ~rx_s;
        end
      default:
      begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: uart_cmd_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_dispatch (
  input  logic                           clk,
  input  logic                           rst_n,
  input  uart_pkg::cmd_t                 cmd_in,
  input  uart_pkg::chan_t                cmd_chan,
  input  logic                           cmd_vld,
  input  logic [uart_pkg::NUM_CHAN-1:0]  idle,
  output logic                           cmd_rdy,
  output logic [uart_pkg::NUM_CHAN-1:0]  start,
  output uart_pkg::cmd_t                 cmd
);

  import uart_pkg::*;

  logic                full;
  logic                accept;
  chan_t               chan_q;   // Target of the buffered command.
  logic [NUM_CHAN-1:0] target;

  assign accept  = cmd_vld & cmd_rdy;
  assign cmd_rdy = ~full;

  assign target = NUM_CHAN'(1) << chan_q;

  // Start only while the addressed channel reports idle.
  assign start = full ? (target & idle) : '0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (accept)
    begin
      full <= 1'b1;
    end
    else if (|start)
    begin
      full <= 1'b0;   // Handed over, buffer free next cycle.
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd    <= cmd_in;
      chan_q <= cmd_chan;
    end
  end

endmodule

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int NUM_CHAN     = 4;
  localparam int CHAN_W       = $clog2(NUM_CHAN);
  localparam int CMD_W        = 16;
  localparam int BYTE_W       = 8;
  localparam int IDX_W        = $clog2(BYTE_W);
  localparam int CLKS_PER_BIT = 16;    // Short bit time for simulation.
  localparam int GAP_BITS     = 2;     // Idle bit times between write frames.
  localparam int GAP_CLKS     = GAP_BITS * CLKS_PER_BIT;
  localparam int MID_CNT      = CLKS_PER_BIT / 2 - 1;
  // Counter must hold the gap length as well as one bit time.
  localparam int CNT_W        = $clog2(GAP_CLKS > CLKS_PER_BIT ? GAP_CLKS : CLKS_PER_BIT);

  typedef logic [CMD_W-1:0]  cmd_t;
  typedef logic [BYTE_W-1:0] uart_byte_t;
  typedef logic [CHAN_W-1:0] chan_t;

  typedef enum logic [3:0] {
    IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP,
    GAP,
    RX_WAIT,
    RX_DATA,
    RX_PARITY,
    RX_STOP,
    DONE
  } chan_state_t;

endpackage

`default_nettype wire
